//--- sim.f
+incdir+hdl
hdl/issuePkg.sv
hdl/uopBus.sv
hdl/dispatchStage.sv
hdl/reservationStation.sv
hdl/execPipes.sv
hdl/issueCore.sv
testbench/issueCore_sva.sv
testbench/issueCoreTb.sv

//--- Makefile
TOP = issueCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- testbench/issueCoreTb.sv
`default_nettype none

module issueCoreTb;

    localparam int numRows = 12;
    localparam int firstStore = 5;
    // Pass one, pass two, then the rows re-sent after the flush
    localparam int totalRows = 2 * numRows + (numRows - firstStore);
    localparam int cycleLimit = 20 * totalRows + 100;

    logic clk;
    logic rst;
    logic inValid;
    issuePkg::FuncUnit inFu;
    issuePkg::OpCode inOpcode;
    issuePkg::Tag inTagA;
    issuePkg::Tag inTagB;
    issuePkg::Tag inTagDst;
    logic inReady;
    logic flush;
    issuePkg::SeqNum flushSeq;
    issuePkg::SeqNum commitSeq = '0;
    logic issue0Valid;
    issuePkg::SeqNum issue0Seq;
    logic issue1Valid;
    issuePkg::SeqNum issue1Seq;
    logic [1:0] resultValid;
    issuePkg::Tag [1:0] resultTag;
    issuePkg::FreeCount freeCount;

    // Class column holds 0 for simple int, 1 branch, 2 load, 3 store
    issuePkg::FuncUnit fuT [numRows];
    issuePkg::OpCode opT [numRows];
    issuePkg::Tag tagAT [numRows];
    issuePkg::Tag tagBT [numRows];
    issuePkg::Tag tagDstT [numRows];
    int clsT [numRows];

    logic dispatched [numRows];
    logic issued [numRows];
    logic bcast [numRows];
    int base;
    int curRow;
    int cycle;
    int errors;
    int passCount;
    int failCount;
    int seed;
    logic holdCommit;

    issueCore dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic setRow(int i, issuePkg::FuncUnit fu, issuePkg::OpCode op,
                          int a, int b, int d, int cls);
        fuT[i] = fu;
        opT[i] = op;
        tagAT[i] = issuePkg::Tag'(a);
        tagBT[i] = issuePkg::Tag'(b);
        tagDstT[i] = issuePkg::Tag'(d);
        clsT[i] = cls;
    endtask

    // Tags from 40 up are never produced
    task automatic loadTable;
        setRow(0, issuePkg::FU_INT, issuePkg::INT_ADD, 40, 41, 1, 0);
        setRow(1, issuePkg::FU_LSU, issuePkg::LSU_LW, 1, 42, 2, 2);
        setRow(2, issuePkg::FU_INT, issuePkg::INT_SUB, 2, 1, 3, 0);
        setRow(3, issuePkg::FU_INT, issuePkg::INT_BEQ, 3, 43, 4, 1);
        setRow(4, issuePkg::FU_INT, issuePkg::INT_AND, 44, 45, 5, 0);
        setRow(5, issuePkg::FU_LSU, issuePkg::LSU_SW, 3, 5, 6, 3);
        setRow(6, issuePkg::FU_LSU, issuePkg::LSU_LB, 40, 41, 7, 2);
        setRow(7, issuePkg::FU_INT, issuePkg::INT_ADD, 7, 5, 8, 0);
        setRow(8, issuePkg::FU_LSU, issuePkg::LSU_SB, 8, 2, 9, 3);
        setRow(9, issuePkg::FU_INT, issuePkg::INT_JAL, 46, 47, 10, 1);
        setRow(10, issuePkg::FU_LSU, issuePkg::LSU_LW, 9, 8, 11, 2);
        setRow(11, issuePkg::FU_INT, issuePkg::INT_ADD, 11, 10, 12, 0);
    endtask

    task automatic clearState;
        for (int i = 0; i < numRows; i++) begin
            dispatched[i] = 1'b0;
            issued[i] = 1'b0;
            bcast[i] = 1'b0;
        end
    endtask

    task automatic checkBroadcast(issuePkg::Tag tag);
        int r;
        r = -1;
        for (int i = 0; i < numRows; i++) begin
            if (dispatched[i] && issued[i] && tagDstT[i] == tag)
                r = i;
        end
        assert (r >= 0) else begin
            $display("Tag %h was broadcast with no issued producer", tag);
            errors++;
        end
        if (r >= 0) begin
            assert (!bcast[r]) else begin
                $display("error resultTag 0x%h broadcast a second time", tag);
                errors++;
            end
            bcast[r] = 1'b1;
        end
    endtask

    task automatic checkSource(int r, issuePkg::Tag src, issuePkg::SeqNum seq);
        for (int k = 0; k < r; k++) begin
            if (tagDstT[k] == src) begin
                assert (bcast[k]) else begin
                    $display("Seq %h issued before source tag %h was broadcast", seq, src);
                    errors++;
                end
            end
        end
    endtask

    task automatic checkIssue(issuePkg::SeqNum seq, int port);
        int r;
        r = (int'(seq) - base + 64) % 64;
        assert (r < numRows && dispatched[r]) else begin
            $display("Seq %h issued on port %0d without a live dispatch", seq, port);
            errors++;
        end
        if (r < numRows && dispatched[r]) begin
            assert (!issued[r]) else begin
                $display("Seq %h issued more than once", seq);
                errors++;
            end
            issued[r] = 1'b1;
            if (port == 1) begin
                assert (clsT[r] == 0) else begin
                    $display("error issue1Seq 0x%h has class 0x%h", seq, clsT[r]);
                    errors++;
                end
            end
            if (clsT[r] == 3) begin
                assert (commitSeq == seq) else begin
                    $display("error commitSeq 0x%h at store issue 0x%h", commitSeq, seq);
                    errors++;
                end
            end
            if (clsT[r] >= 2) begin
                for (int k = 0; k < r; k++) begin
                    if (clsT[k] == 3) begin
                        assert (issued[k]) else begin
                            $display("Memory op %h issued ahead of an older store", seq);
                            errors++;
                        end
                    end
                end
            end
            checkSource(r, tagAT[r], seq);
            checkSource(r, tagBT[r], seq);
        end
    endtask

    // Sampled before the edge updates the DUT
    always @(posedge clk) begin
        if (!rst) begin
            cycle = cycle + 1;
            if (inValid && inReady)
                dispatched[curRow] = 1'b1;
            for (int p = 0; p < 2; p++) begin
                if (resultValid[p])
                    checkBroadcast(resultTag[p]);
            end
            if (issue0Valid)
                checkIssue(issue0Seq, 0);
            if (issue1Valid)
                checkIssue(issue1Seq, 1);
            if (flush) begin
                for (int i = (int'(flushSeq) - base + 65) % 64; i < numRows; i++) begin
                    dispatched[i] = 1'b0;
                    issued[i] = 1'b0;
                    bcast[i] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cycle > cycleLimit) begin
            $display("Timeout after %0d cycles with micro-ops still outstanding", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Commit follows the oldest seq not yet seen issuing
    always @(negedge clk) begin
        int oldest;
        oldest = numRows;
        for (int i = numRows - 1; i >= 0; i--) begin
            if (!issued[i])
                oldest = i;
        end
        if (holdCommit)
            commitSeq <= issuePkg::SeqNum'(base + firstStore - 1);
        else
            commitSeq <= issuePkg::SeqNum'(base + oldest);
    end

    task automatic dispatchRow(int i);
        int gap;
        gap = ($random(seed) & 32'h7fff_ffff) % 3;
        repeat (gap) @(negedge clk);
        curRow = i;
        inFu = fuT[i];
        inOpcode = opT[i];
        inTagA = tagAT[i];
        inTagB = tagBT[i];
        inTagDst = tagDstT[i];
        inValid = 1'b1;
        do
            @(posedge clk);
        while (!inReady);
        @(negedge clk);
        inValid = 1'b0;
    endtask

    function automatic logic allDone;
        logic done;
        done = 1'b1;
        for (int i = 0; i < numRows; i++)
            done = done && issued[i] && bcast[i];
        return done;
    endfunction

    task automatic waitDrain;
        while (!allDone())
            @(negedge clk);
        repeat (2) @(negedge clk);
        assert (freeCount == 4'd8) else begin
            $display("error freeCount 0x%h after drain, expected 0x8", freeCount);
            errors++;
        end
    endtask

    task automatic reportTest(string name, int errBefore);
        if (errors == errBefore) begin
            passCount++;
            $display("Test %s: pass", name);
        end else begin
            failCount++;
            $display("Test %s: fail with %0d errors", name, errors - errBefore);
        end
    endtask

    initial begin
        int errBefore;
        seed = 60;
        rst = 1'b1;
        inValid = 1'b0;
        inFu = issuePkg::FU_INT;
        inOpcode = issuePkg::INT_ADD;
        inTagA = '0;
        inTagB = '0;
        inTagDst = '0;
        flush = 1'b0;
        flushSeq = '0;
        holdCommit = 1'b0;
        base = 0;
        curRow = 0;
        cycle = 0;
        errors = 0;
        passCount = 0;
        failCount = 0;
        loadTable();
        clearState();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errBefore = errors;
        for (int i = 0; i < numRows; i++)
            dispatchRow(i);
        waitDrain();
        reportTest("in-order run", errBefore);

        // Stores stay blocked, so the younger half is still held at the flush
        errBefore = errors;
        clearState();
        base = numRows;
        holdCommit = 1'b1;
        for (int i = 0; i < numRows; i++)
            dispatchRow(i);
        repeat (10) @(negedge clk);
        flush = 1'b1;
        flushSeq = issuePkg::SeqNum'(base + firstStore - 1);
        @(negedge clk);
        flush = 1'b0;
        holdCommit = 1'b0;
        for (int i = firstStore; i < numRows; i++)
            dispatchRow(i);
        waitDrain();
        reportTest("flush and re-dispatch", errBefore);

        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errors);
        if (failCount == 0 && errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/issueCore_sva.sv
`default_nettype none

module issueCore_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic flush,
    input wire logic inReady,
    input wire logic issue0Valid,
    input wire logic issue1Valid,
    input wire issuePkg::SeqNum issue0Seq,
    input wire issuePkg::SeqNum issue1Seq,
    input wire logic [1:0] resultValid,
    input wire issuePkg::FreeCount freeCount,
    input wire logic dispValid,
    input wire logic dispReady,
    input wire issuePkg::SeqNum dispSeq,
    input wire logic i0Valid,
    input wire logic i0Ready,
    input wire issuePkg::SeqNum i0Seq,
    input wire logic i1Valid,
    input wire logic i1Ready,
    input wire issuePkg::SeqNum i1Seq
);

    // A stalled sender keeps its micro-op unless a flush drops it
    dispHeld: assert property (@(posedge clk) disable iff (rst)
        dispValid && !dispReady && !flush |=> dispValid && $stable(dispSeq))
        else $error("dispatch bus dropped a stalled micro-op");

    issue0Held: assert property (@(posedge clk) disable iff (rst)
        i0Valid && !i0Ready && !flush |=> i0Valid && $stable(i0Seq))
        else $error("issue0 bus dropped a stalled micro-op");

    issue1Held: assert property (@(posedge clk) disable iff (rst)
        i1Valid && !i1Ready && !flush |=> i1Valid && $stable(i1Seq))
        else $error("issue1 bus dropped a stalled micro-op");

    resetState: assert property (@(posedge clk) $fell(rst) |->
        !issue0Valid && !issue1Valid && resultValid == 2'b00 && inReady && freeCount == 4'd8)
        else $error("outputs not in reset state after reset");

    freeRange: assert property (@(posedge clk) disable iff (rst) freeCount <= 4'd8)
        else $error("freeCount above station depth");

    distinctSeq: assert property (@(posedge clk) disable iff (rst)
        !(issue0Valid && issue1Valid && issue0Seq == issue1Seq))
        else $error("both ports issued the same seq");

endmodule

bind issueCore issueCore_sva sva (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .inReady(inReady),
    .issue0Valid(issue0Valid),
    .issue1Valid(issue1Valid),
    .issue0Seq(issue0Seq),
    .issue1Seq(issue1Seq),
    .resultValid(resultValid),
    .freeCount(freeCount),
    .dispValid(dispBus.valid),
    .dispReady(dispBus.ready),
    .dispSeq(dispBus.uop.seq),
    .i0Valid(issue0.valid),
    .i0Ready(issue0.ready),
    .i0Seq(issue0.uop.seq),
    .i1Valid(issue1.valid),
    .i1Ready(issue1.ready),
    .i1Seq(issue1.uop.seq)
);

`default_nettype wire

//--- hdl/issueCore.sv
`default_nettype none

module issueCore (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  issuePkg::FuncUnit inFu,
    input  issuePkg::OpCode inOpcode,
    input  issuePkg::Tag inTagA,
    input  issuePkg::Tag inTagB,
    input  issuePkg::Tag inTagDst,
    output logic inReady,
    input  logic flush,
    input  issuePkg::SeqNum flushSeq,
    input  issuePkg::SeqNum commitSeq,
    output logic issue0Valid,
    output issuePkg::SeqNum issue0Seq,
    output logic issue1Valid,
    output issuePkg::SeqNum issue1Seq,
    output logic [1:0] resultValid,
    output issuePkg::Tag [1:0] resultTag,
    output issuePkg::FreeCount freeCount
);

    uopBus dispBus();
    uopBus issue0();
    uopBus issue1();

    issuePkg::Uop inUop;

    // Availability and seq are filled in by dispatch
    assign inUop = '{
        fu: inFu,
        opcode: inOpcode,
        tagA: inTagA,
        availA: 1'b0,
        tagB: inTagB,
        availB: 1'b0,
        tagDst: inTagDst,
        seq: '0
    };

    assign issue0Valid = issue0.valid && issue0.ready;
    assign issue0Seq = issue0.uop.seq;
    assign issue1Valid = issue1.valid && issue1.ready;
    assign issue1Seq = issue1.uop.seq;

    dispatchStage dispatch (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inUop(inUop),
        .inReady(inReady),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .flush(flush),
        .flushSeq(flushSeq),
        .out(dispBus)
    );

    reservationStation station (
        .clk(clk),
        .rst(rst),
        .in(dispBus),
        .issue0(issue0),
        .issue1(issue1),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .flush(flush),
        .flushSeq(flushSeq),
        .commitSeq(commitSeq),
        .freeCount(freeCount)
    );

    execPipes pipes (
        .clk(clk),
        .rst(rst),
        .issue0(issue0),
        .issue1(issue1),
        .flush(flush),
        .flushSeq(flushSeq),
        .resultValid(resultValid),
        .resultTag(resultTag)
    );

endmodule

`default_nettype wire

//--- hdl/execPipes.sv
`default_nettype none

`include "issue_macros.svh"

module execPipes (
    input  logic clk,
    input  logic rst,
    uopBus.receiver issue0,
    uopBus.receiver issue1,
    input  logic flush,
    input  issuePkg::SeqNum flushSeq,
    output logic [1:0] resultValid,
    output issuePkg::Tag [1:0] resultTag
);

    localparam int depth = `LAT_COMPLEX;
    // Simple ops skip the leading stages
    localparam int simpleStage = `LAT_COMPLEX - `LAT_SIMPLE;

    logic [depth-1:0] stgValid [2];
    issuePkg::Tag stgTag [2][depth];
    issuePkg::SeqNum stgSeq [2][depth];

    logic [1:0] takeValid;
    issuePkg::Uop takeUop [2];
    logic [1:0] busy;
    int entryStage [2];

    assign takeUop[0] = issue0.uop;
    assign takeUop[1] = issue1.uop;
    assign takeValid = {issue1.valid && issue1.ready, issue0.valid && issue0.ready};
    assign issue0.ready = !busy[0];
    assign issue1.ready = !busy[1];

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            busy[p] = 1'b0;
            for (int k = 0; k < simpleStage; k++)
                busy[p] = busy[p] | stgValid[p][k];
            // Pipe 1 only ever runs simple ops
            entryStage[p] = (p == 1 || issuePkg::isSimple(takeUop[p])) ? simpleStage : 0;
            resultValid[p] = stgValid[p][depth-1] &&
                !(flush && issuePkg::isYounger(stgSeq[p][depth-1], flushSeq));
            resultTag[p] = stgTag[p][depth-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stgValid[0] <= '0;
            stgValid[1] <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                for (int k = depth - 1; k > 0; k--) begin
                    stgValid[p][k] <= stgValid[p][k-1] &&
                        !(flush && issuePkg::isYounger(stgSeq[p][k-1], flushSeq));
                    stgTag[p][k] <= stgTag[p][k-1];
                    stgSeq[p][k] <= stgSeq[p][k-1];
                end
                stgValid[p][0] <= 1'b0;

                if (takeValid[p] && !(flush && issuePkg::isYounger(takeUop[p].seq, flushSeq))) begin
                    stgValid[p][entryStage[p]] <= 1'b1;
                    stgTag[p][entryStage[p]] <= takeUop[p].tagDst;
                    stgSeq[p][entryStage[p]] <= takeUop[p].seq;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/reservationStation.sv
`default_nettype none

`include "issue_macros.svh"

module reservationStation (
    input  logic clk,
    input  logic rst,
    uopBus.receiver in,
    uopBus.sender issue0,
    uopBus.sender issue1,
    input  logic [1:0] resultValid,
    input  issuePkg::Tag [1:0] resultTag,
    input  logic flush,
    input  issuePkg::SeqNum flushSeq,
    input  issuePkg::SeqNum commitSeq,
    output issuePkg::FreeCount freeCount
);

    localparam int depth = `RS_DEPTH;
    localparam int idxW = $clog2(`RS_DEPTH);

    issuePkg::Uop ent [depth];
    logic [depth-1:0] entValid;
    logic [depth-1:0] eligible;

    // Seqs of held stores in program order
    issuePkg::SeqNum sq [depth];
    logic [idxW:0] sqHead;
    logic [idxW:0] sqTail;
    logic [idxW:0] sqUsed;
    logic [idxW:0] sqKeep;
    logic [idxW-1:0] sqPos;
    logic sqEmpty;

    logic [1:0] issValid;
    issuePkg::Uop issUop [2];
    logic [1:0] issReady;
    logic [1:0] canLoad;
    logic [1:0] selValid;
    logic [idxW-1:0] selIdx [2];
    logic [idxW-1:0] allocIdx;
    logic hasFree;

    assign issue0.valid = issValid[0];
    assign issue0.uop = issUop[0];
    assign issue1.valid = issValid[1];
    assign issue1.uop = issUop[1];
    assign issReady = {issue1.ready, issue0.ready};
    assign canLoad = ~issValid | issReady;

    assign sqEmpty = sqHead == sqTail;
    assign in.ready = hasFree && !flush;

    always_comb begin
        freeCount = '0;
        hasFree = 1'b0;
        allocIdx = '0;
        for (int j = depth - 1; j >= 0; j--) begin
            if (!entValid[j]) begin
                hasFree = 1'b1;
                allocIdx = idxW'(j);
            end
            freeCount = freeCount + issuePkg::FreeCount'(!entValid[j]);
        end
    end

    always_comb begin
        for (int j = 0; j < depth; j++) begin
            eligible[j] = entValid[j] && ent[j].availA && ent[j].availB;
            // Loads wait for every older store
            if (issuePkg::isLoad(ent[j]) && !sqEmpty &&
                !issuePkg::isYounger(sq[sqHead[idxW-1:0]], ent[j].seq))
                eligible[j] = 1'b0;
            // Stores leave in order and only at commit
            if (issuePkg::isStore(ent[j]) &&
                (sq[sqHead[idxW-1:0]] != ent[j].seq || commitSeq != ent[j].seq))
                eligible[j] = 1'b0;
        end
    end

    // Oldest eligible entry per port, port 1 gets simple ops only
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            selValid[p] = 1'b0;
            selIdx[p] = '0;
            for (int j = 0; j < depth; j++) begin
                if (eligible[j] && canLoad[p] &&
                    (p == 0 || issuePkg::isSimple(ent[j])) &&
                    !(p == 1 && selValid[0] && selIdx[0] == idxW'(j)) &&
                    (!selValid[p] || issuePkg::isYounger(ent[selIdx[p]].seq, ent[j].seq))) begin
                    selValid[p] = 1'b1;
                    selIdx[p] = idxW'(j);
                end
            end
        end
    end

    // Flushed stores form a suffix of the queue
    always_comb begin
        sqUsed = sqTail - sqHead;
        sqKeep = '0;
        sqPos = '0;
        for (int k = 0; k < depth; k++) begin
            sqPos = sqHead[idxW-1:0] + idxW'(k);
            if (k < sqUsed && !issuePkg::isYounger(sq[sqPos], flushSeq))
                sqKeep = sqKeep + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            issValid <= '0;
            sqHead <= '0;
            sqTail <= '0;
        end else begin
            for (int j = 0; j < depth; j++)
                ent[j] <= issuePkg::wake(ent[j], resultValid, resultTag);

            if (flush) begin
                for (int j = 0; j < depth; j++) begin
                    if (issuePkg::isYounger(ent[j].seq, flushSeq))
                        entValid[j] <= 1'b0;
                end
                for (int p = 0; p < 2; p++) begin
                    if (issReady[p] || issuePkg::isYounger(issUop[p].seq, flushSeq))
                        issValid[p] <= 1'b0;
                end
                sqTail <= sqHead + sqKeep;
            end else begin
                for (int p = 0; p < 2; p++) begin
                    if (canLoad[p]) begin
                        issValid[p] <= selValid[p];
                        if (selValid[p]) begin
                            issUop[p] <= ent[selIdx[p]];
                            entValid[selIdx[p]] <= 1'b0;
                        end
                    end
                end
                if (selValid[0] && issuePkg::isStore(ent[selIdx[0]]))
                    sqHead <= sqHead + 1'b1;

                if (in.valid && hasFree) begin
                    ent[allocIdx] <= issuePkg::wake(in.uop, resultValid, resultTag);
                    entValid[allocIdx] <= 1'b1;
                    if (issuePkg::isStore(in.uop)) begin
                        sq[sqTail[idxW-1:0]] <= in.uop.seq;
                        sqTail <= sqTail + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dispatchStage.sv
`default_nettype none

`include "issue_macros.svh"

module dispatchStage (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  issuePkg::Uop inUop,
    output logic inReady,
    input  logic [1:0] resultValid,
    input  issuePkg::Tag [1:0] resultTag,
    input  logic flush,
    input  issuePkg::SeqNum flushSeq,
    uopBus.sender out
);

    localparam int numTags = 1 << `TAG_W;

    // Pending destination tags and the age of their producer
    logic [numTags-1:0] pending;
    issuePkg::SeqNum pendSeq [numTags];

    issuePkg::SeqNum nextSeq;
    logic outValid;
    issuePkg::Uop outUop;
    issuePkg::Uop stamped;
    logic accept;

    assign inReady = (!outValid || out.ready) && !flush;
    assign accept = inValid && inReady;
    assign out.valid = outValid;
    assign out.uop = outUop;

    always_comb begin
        stamped = inUop;
        stamped.seq = nextSeq;
        stamped.availA = !pending[inUop.tagA];
        stamped.availB = !pending[inUop.tagB];
        stamped = issuePkg::wake(stamped, resultValid, resultTag);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            nextSeq <= '0;
            outValid <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (resultValid[i])
                    pending[resultTag[i]] <= 1'b0;
            end

            // A held micro-op still listens to the broadcast
            outUop <= issuePkg::wake(outUop, resultValid, resultTag);

            if (flush) begin
                for (int t = 0; t < numTags; t++) begin
                    if (pending[t] && issuePkg::isYounger(pendSeq[t], flushSeq))
                        pending[t] <= 1'b0;
                end
                if (outValid && issuePkg::isYounger(outUop.seq, flushSeq))
                    outValid <= 1'b0;
                nextSeq <= flushSeq + 1'b1;
            end else begin
                if (outValid && out.ready)
                    outValid <= 1'b0;
                if (accept) begin
                    outValid <= 1'b1;
                    outUop <= stamped;
                    pending[inUop.tagDst] <= 1'b1;
                    pendSeq[inUop.tagDst] <= nextSeq;
                    nextSeq <= nextSeq + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/uopBus.sv
`default_nettype none

interface uopBus;

    logic valid;
    logic ready;
    issuePkg::Uop uop;

    modport sender (
        output valid,
        output uop,
        input  ready
    );

    modport receiver (
        input  valid,
        input  uop,
        output ready
    );

endinterface

`default_nettype wire

//--- hdl/issuePkg.sv
`default_nettype none

`include "issue_macros.svh"

package issuePkg;

    typedef logic [`TAG_W-1:0] Tag;
    typedef logic [`SEQ_W-1:0] SeqNum;
    typedef logic [3:0] FreeCount;

    typedef enum logic {
        FU_INT,
        FU_LSU
    } FuncUnit;

    typedef enum logic [3:0] {
        INT_ADD,
        INT_SUB,
        INT_AND,
        INT_BEQ,
        INT_BNE,
        INT_JAL,
        LSU_LW,
        LSU_LB,
        LSU_SW,
        LSU_SB
    } OpCode;

    typedef struct packed {
        FuncUnit fu;
        OpCode opcode;
        Tag tagA;
        logic availA;
        Tag tagB;
        logic availB;
        Tag tagDst;
        SeqNum seq;
    } Uop;

    function automatic logic isLoad(Uop u);
        return u.fu == FU_LSU && (u.opcode == LSU_LW || u.opcode == LSU_LB);
    endfunction

    function automatic logic isStore(Uop u);
        return u.fu == FU_LSU && (u.opcode == LSU_SW || u.opcode == LSU_SB);
    endfunction

    // Branches and memory ops take the long pipe
    function automatic logic isSimple(Uop u);
        return u.fu == FU_INT && !(u.opcode inside {INT_BEQ, INT_BNE, INT_JAL});
    endfunction

    // True when a is younger than b, using the wrapped difference
    function automatic logic isYounger(SeqNum a, SeqNum b);
        SeqNum diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    // Marks sources that appear on the result broadcast this cycle
    function automatic Uop wake(Uop u, logic [1:0] valid, Tag [1:0] tag);
        Uop r;
        r = u;
        for (int i = 0; i < 2; i++) begin
            if (valid[i] && u.tagA == tag[i])
                r.availA = 1'b1;
            if (valid[i] && u.tagB == tag[i])
                r.availB = 1'b1;
        end
        return r;
    endfunction

endpackage

`default_nettype wire

//--- hdl/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Reservation station entries
`define RS_DEPTH 8

// Physical register tag width
`define TAG_W 6

// Age numbers wrap, so at most 31 micro-ops may be in flight
`define SEQ_W 6

// Execution latency in cycles per class
`define LAT_SIMPLE 1
`define LAT_COMPLEX 2

`endif
